//--- sim.f
riscv_pkg.sv
if_stage.sv
decoder.sv
dec.sv
rf.sv
csr_file.sv
exe.sv
rv_decexe_top.sv
dec_asserts.sv
tb_rv_decexe.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_decexe
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
	  echo "FAIL: see $(LOG)"; exit 1; \
	else \
	  echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_rv_decexe.sv
`timescale 1ns/1ps

module tb_rv_decexe;
  import riscv_pkg::*;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam int          CLK_NS    = 8;
  localparam int          N_RAND    = 120;
  // Directed tests issue fewer than this many instructions
  localparam int          N_INSTR   = N_RAND + 250;
  localparam logic [6:0]  I_ALU     = 7'b0010011;
  localparam logic [6:0]  R_ALU     = 7'b0110011;
  localparam logic [6:0]  U_LUI     = 7'b0110111;
  localparam logic [6:0]  U_AUIPC   = 7'b0010111;
  localparam logic [6:0]  SYS       = 7'b1110011;
  localparam logic [31:0] EDGES [0:4] = '{32'h0000_0000, 32'h0000_0001, 32'h7FFF_FFFF,
                                          32'h8000_0000, 32'hFFFF_FFFF};

  logic        clk = 1'b0;
  logic        reset_n;
  instr_in_t   instr_drv;
  wb_t         wb;

  logic [31:0] model_x [0:31];
  logic [31:0] model_csr [0:3];
  logic [31:0] model_pc;
  wb_t         exp_q [$];
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;

  rv_decexe_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) rv_decexe_top_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .instr_i (instr_drv),
    .wb_o    (wb)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // ------------------------------------------------------------------
  // Instruction encoders and reference model
  // ------------------------------------------------------------------
  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, R_ALU};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // Bit 2 flags an address outside the four machine CSRs
  function automatic logic [2:0] csr_index(logic [11:0] adr);
    case (adr)
      12'h305: return 3'd0;
      12'h340: return 3'd1;
      12'h341: return 3'd2;
      12'h342: return 3'd3;
      default: return 3'd4;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Update the model, queue the expected write, then drive the instruction
  task automatic issue(input logic [31:0] ins);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [2:0]  ci;
    logic [31:0] a;
    logic [31:0] old;
    logic [31:0] res;
    rd  = ins[11:7];
    rs1 = ins[19:15];
    f3  = ins[14:12];
    a   = model_x[rs1];
    res = '0;
    case (ins[6:0])
      I_ALU:   res = alu_ref(f3, ins[30] && f3 == 3'd5, a, {{20{ins[31]}}, ins[31:20]});
      R_ALU:   res = alu_ref(f3, ins[30], a, model_x[ins[24:20]]);
      U_LUI:   res = {ins[31:12], 12'd0};
      U_AUIPC: res = model_pc + {ins[31:12], 12'd0};
      SYS: begin
        ci  = csr_index(ins[31:20]);
        old = ci[2] ? '0 : model_csr[ci[1:0]];
        res = old;
        if (!ci[2] && (f3 == 3'd1 || rs1 != 5'd0)) begin
          case (f3)
            3'd1:    model_csr[ci[1:0]] = a;
            3'd2:    model_csr[ci[1:0]] = old | a;
            default: model_csr[ci[1:0]] = old & ~a;
          endcase
        end
      end
      default: ;
    endcase
    model_pc = model_pc + 32'd4;
    if (rd != 5'd0) begin
      model_x[rd] = res;
      exp_q.push_back('{v: 1'b1, adr: rd, data: res});
    end
    @(posedge clk);
    instr_drv <= '{valid: 1'b1, instr: ins};
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_drv <= '{valid: 1'b0, instr: 32'h0};
    end
  endtask

  // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    issue(u_type(hi[31:12], rd, U_LUI));
    issue(i_type(v[11:0], rd, 3'd0, rd, I_ALU));
  endtask

  task automatic csr_access(input logic [2:0] f3, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [11:0] adr);
    issue(i_type(adr, rs1, f3, rd, SYS));
  endtask

  // Drain the pipeline, then a few idle cycles to catch stray writes
  task automatic end_test(input string name, input int e0);
    idle(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    idle(6);
    tests++;
    $display("%s finished with %0d errors", name, errors - e0);
  endtask

  function automatic logic [11:0] csr_pick();
    case ($urandom_range(0, 4))
      0:       return 12'h305;
      1:       return 12'h340;
      2:       return 12'h341;
      3:       return 12'h342;
      default: return 12'h7C0;
    endcase
  endfunction

  function automatic logic [31:0] random_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    rd  = 5'($urandom_range(0, 15));
    rs1 = 5'($urandom_range(0, 15));
    rs2 = 5'($urandom_range(0, 15));
    f3  = 3'($urandom_range(0, 7));
    alt = 1'($urandom_range(0, 1));
    imm = 12'($urandom);
    case ($urandom_range(0, 5))
      0, 1: return r_type((f3 == 3'd0 || f3 == 3'd5) && alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
      2: begin
        if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
        if (f3 == 3'd5) imm = {1'b0, alt, 5'd0, imm[4:0]};
        return i_type(imm, rs1, f3, rd, I_ALU);
      end
      3:       return u_type(20'($urandom), rd, U_LUI);
      4:       return u_type(20'($urandom), rd, U_AUIPC);
      default: return i_type(csr_pick(), rs1, 3'($urandom_range(1, 3)), rd, SYS);
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Writeback checker, sampled away from the active edge
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    wb_t exp;
    if (reset_n !== 1'b1) begin
      assert (wb.v !== 1'b1) else begin
        $display("wb_o.v went high while reset was asserted");
        errors++;
      end
    end else if (wb.v) begin
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("write to x%0d on wb_o with no expected write pending", wb.adr);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        assert (wb.adr == exp.adr) else begin
          $display("ERROR wb_o.adr: expected %h, got %h", exp.adr, wb.adr);
          errors++;
        end
        assert (wb.data == exp.data) else begin
          $display("ERROR wb_o.data: expected %h, got %h (x%0d)", exp.data, wb.data, exp.adr);
          errors++;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic reset_and_bubbles();
    int e0;
    e0 = errors;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    idle(10);
    issue(i_type(12'h005, 5'd0, 3'd0, 5'd0, I_ALU));
    issue(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    issue(u_type(20'hFFFFF, 5'd0, U_LUI));
    csr_access(3'd2, 5'd0, 5'd0, 12'h340);
    issue(i_type(12'h007, 5'd0, 3'd0, 5'd1, I_ALU));
    end_test("reset_and_bubbles", e0);
  endtask

  task automatic immediate_ops();
    int e0;
    e0 = errors;
    issue(i_type(12'h123, 5'd0, 3'd0, 5'd1, I_ALU));
    issue(i_type(12'h7FF, 5'd1, 3'd4, 5'd2, I_ALU));
    issue(i_type(12'hFFF, 5'd1, 3'd6, 5'd3, I_ALU));
    issue(i_type(12'h0F0, 5'd3, 3'd7, 5'd4, I_ALU));
    issue(i_type(12'h01F, 5'd1, 3'd1, 5'd5, I_ALU));
    issue(u_type(20'h80000, 5'd6, U_LUI));
    issue(i_type(12'h004, 5'd6, 3'd5, 5'd7, I_ALU));
    issue(i_type(12'h404, 5'd6, 3'd5, 5'd8, I_ALU));
    issue(i_type(12'hFFF, 5'd6, 3'd2, 5'd9, I_ALU));
    issue(i_type(12'hFFF, 5'd1, 3'd3, 5'd10, I_ALU));
    issue(u_type(20'hABCDE, 5'd11, U_LUI));
    issue(u_type(20'h12345, 5'd12, U_AUIPC));
    idle(2);
    issue(u_type(20'h00000, 5'd13, U_AUIPC));
    end_test("immediate_ops", e0);
  endtask

  // Instruction i depends on instruction i-d through the same destination
  task automatic dependency_chains();
    int         e0;
    logic [4:0] dst;
    logic [4:0] src;
    e0 = errors;
    for (int k = 1; k <= 4; k++) begin
      load_const(5'(k), 32'(k) * 32'h1357_9BDF);
    end
    for (int d = 1; d <= 4; d++) begin
      for (int i = 0; i < 8; i++) begin
        dst = 5'(8 + i % d);
        src = 5'(1 + i % 4);
        case (i % 3)
          0:       issue(r_type(7'h00, src, dst, 3'd0, dst));
          1:       issue(r_type(7'h00, dst, src, 3'd4, dst));
          default: issue(r_type(7'h20, src, dst, 3'd0, dst));
        endcase
      end
    end
    end_test("dependency_chains", e0);
  endtask

  task automatic compare_edges();
    int e0;
    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      load_const(5'(i + 1), EDGES[i]);
    end
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        issue(r_type(7'h20, 5'(j + 1), 5'(i + 1), 3'd0, 5'd10));
        issue(r_type(7'h00, 5'(j + 1), 5'(i + 1), 3'd2, 5'd11));
        issue(r_type(7'h00, 5'(j + 1), 5'(i + 1), 3'd3, 5'd12));
      end
    end
    end_test("compare_edges", e0);
  endtask

  task automatic csr_sequences();
    int e0;
    e0 = errors;
    load_const(5'd2, 32'hA5A5_0F0F);
    load_const(5'd4, 32'h1234_5678);
    load_const(5'd6, 32'h0000_00F0);
    load_const(5'd8, 32'h0000_0F00);
    // Same CSR at distances 1, 2 and 3
    csr_access(3'd1, 5'd1, 5'd2, 12'h340);
    csr_access(3'd1, 5'd3, 5'd4, 12'h340);
    csr_access(3'd2, 5'd5, 5'd6, 12'h340);
    idle(1);
    csr_access(3'd3, 5'd7, 5'd8, 12'h340);
    idle(2);
    csr_access(3'd2, 5'd9, 5'd0, 12'h340);
    csr_access(3'd3, 5'd9, 5'd0, 12'h340);
    csr_access(3'd2, 5'd9, 5'd0, 12'h340);
    csr_access(3'd1, 5'd0, 5'd2, 12'h305);
    csr_access(3'd1, 5'd0, 5'd4, 12'h341);
    csr_access(3'd1, 5'd0, 5'd6, 12'h342);
    csr_access(3'd2, 5'd10, 5'd8, 12'h341);
    csr_access(3'd2, 5'd11, 5'd0, 12'h305);
    csr_access(3'd2, 5'd12, 5'd0, 12'h342);
    csr_access(3'd1, 5'd13, 5'd2, 12'h7C0);
    csr_access(3'd2, 5'd14, 5'd0, 12'h7C0);
    csr_access(3'd2, 5'd15, 5'd0, 12'h341);
    end_test("csr_sequences", e0);
  endtask

  task automatic random_mix();
    int e0;
    int gap;
    e0 = errors;
    for (int r = 1; r < 16; r++) begin
      load_const(5'(r), $urandom);
    end
    for (int n = 0; n < N_RAND; n++) begin
      gap = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
      idle(gap);
      issue(random_instr());
    end
    // Read back every register and CSR the mix could touch
    for (int r = 1; r < 16; r++) begin
      issue(i_type(12'h000, 5'(r), 3'd0, 5'(r), I_ALU));
    end
    csr_access(3'd2, 5'd1, 5'd0, 12'h305);
    csr_access(3'd2, 5'd2, 5'd0, 12'h340);
    csr_access(3'd2, 5'd3, 5'd0, 12'h341);
    csr_access(3'd2, 5'd4, 5'd0, 12'h342);
    end_test("random_mix", e0);
  endtask

  initial begin
    reset_n   <= 1'b0;
    instr_drv <= '0;
    model_pc = BOOT_ADDR;
    for (int i = 0; i < 32; i++) begin
      model_x[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      model_csr[i] = '0;
    end
    void'($urandom(32'haf8e_cdac));
    reset_and_bubbles();
    immediate_ops();
    dependency_chains();
    compare_edges();
    csr_sequences();
    random_mix();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && exp_q.size() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((N_INSTR * 8 + 200) * CLK_NS);
    $display("watchdog expired, the pipeline did not drain in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- dec_asserts.sv
`timescale 1ns/1ps

module dec_asserts (
  input logic                clk,
  input logic                reset_n,
  input riscv_pkg::dec_exe_t dec_o,
  input riscv_pkg::wb_t      exe_wb_i,
  input riscv_pkg::wb_t      rf_wb_i
);
  import riscv_pkg::*;

  // x0 writes are squashed in decode
  exe_never_x0: assert property (@(posedge clk) disable iff (!reset_n)
    exe_wb_i.v |-> exe_wb_i.adr != 5'd0)
    else $error("valid exe_wb_i targets x0");

  csr_wbk_unit: assert property (@(posedge clk) disable iff (!reset_n)
    dec_o.csr_wbk |-> dec_o.unit == UNIT_CSR)
    else $error("csr_wbk set outside the CSR unit");

  // Pipeline comes out of reset empty
  quiet_first_cycle: assert property (@(posedge clk)
    $rose(reset_n) |-> !exe_wb_i.v && !rf_wb_i.v)
    else $error("writeback valid in the first cycle after reset");

  // Execute result here comes from the reset value of the decode flops
  quiet_second_cycle: assert property (@(posedge clk)
    $rose(reset_n) |=> !exe_wb_i.v && !rf_wb_i.v)
    else $error("writeback valid in the second cycle after reset");

endmodule

bind dec dec_asserts dec_asserts_inst (
  .clk      (clk),
  .reset_n  (reset_n),
  .dec_o    (dec_o),
  .exe_wb_i (exe_wb_i),
  .rf_wb_i  (rf_wb_i)
);

//--- rv_decexe_top.sv
`timescale 1ns/1ps

module rv_decexe_top #(
  parameter logic [riscv_pkg::XLEN-1:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  riscv_pkg::instr_in_t instr_i,
  output riscv_pkg::wb_t       wb_o
);
  import riscv_pkg::*;

  fetch_t          fetch;
  logic [4:0]      rs1_adr;
  logic [4:0]      rs2_adr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [11:0]     csr_adr;
  logic [XLEN-1:0] csr_data;
  dec_exe_t        dec_exe;
  wb_t             exe_wb;
  csr_wb_t         exe_csr;

  if_stage #(
    .BOOT_ADDR (BOOT_ADDR)
  ) if_stage_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .instr_i (instr_i),
    .fetch_o (fetch)
  );

  dec dec_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .fetch_i    (fetch),
    .rs1_adr_o  (rs1_adr),
    .rs1_data_i (rs1_data),
    .rs2_adr_o  (rs2_adr),
    .rs2_data_i (rs2_data),
    .csr_adr_o  (csr_adr),
    .csr_data_i (csr_data),
    .exe_wb_i   (exe_wb),
    .exe_csr_i  (exe_csr),
    .rf_wb_i    (wb_o),
    .dec_o      (dec_exe)
  );

  // Write stage register doubles as the top-level writeback port
  rf rf_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_adr_i  (rs1_adr),
    .rs1_data_o (rs1_data),
    .rs2_adr_i  (rs2_adr),
    .rs2_data_o (rs2_data),
    .wb_i       (exe_wb),
    .rf_wb_o    (wb_o)
  );

  csr_file csr_file_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .adr_i   (csr_adr),
    .data_o  (csr_data),
    .wb_i    (exe_csr)
  );

  exe exe_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .dec_i     (dec_exe),
    .exe_wb_o  (exe_wb),
    .exe_csr_o (exe_csr)
  );

endmodule

//--- exe.sv
`timescale 1ns/1ps

module exe (
  input  logic                clk,
  input  logic                reset_n,
  input  riscv_pkg::dec_exe_t dec_i,
  output riscv_pkg::wb_t      exe_wb_o,
  output riscv_pkg::csr_wb_t  exe_csr_o
);
  import riscv_pkg::*;

  logic [XLEN-1:0] rd_data;
  logic [XLEN-1:0] csr_data;
  logic            csr_v;

  // ------------------------------------------------------------------
  // ALU and CSR update
  // ------------------------------------------------------------------
  // Same functions feed the distance-1 forward in dec
  assign rd_data  = exe_result(dec_i);
  assign csr_data = csr_next(dec_i);
  // Unknown CSRs never produce a write, so nothing stale gets forwarded
  assign csr_v    = dec_i.csr_wbk && csr_known(dec_i.csr_adr);

  // ------------------------------------------------------------------
  // Result registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      exe_wb_o  <= '0;
      exe_csr_o <= '0;
    end else begin
      exe_wb_o.v     <= dec_i.rd_v;
      exe_wb_o.adr   <= dec_i.rd_adr;
      exe_wb_o.data  <= rd_data;
      exe_csr_o.v    <= csr_v;
      exe_csr_o.adr  <= dec_i.csr_adr;
      exe_csr_o.data <= csr_data;
    end
  end

endmodule

//--- csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [11:0]                adr_i,
  output logic [riscv_pkg::XLEN-1:0] data_o,
  input  riscv_pkg::csr_wb_t         wb_i
);
  import riscv_pkg::*;

  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  always_comb begin
    case (adr_i)
      CSR_MTVEC:    data_o = mtvec_q;
      CSR_MSCRATCH: data_o = mscratch_q;
      CSR_MEPC:     data_o = mepc_q;
      CSR_MCAUSE:   data_o = mcause_q;
      default:      data_o = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (wb_i.v) begin
      case (wb_i.adr)
        CSR_MTVEC:    mtvec_q    <= wb_i.data;
        CSR_MSCRATCH: mscratch_q <= wb_i.data;
        CSR_MEPC:     mepc_q     <= wb_i.data;
        CSR_MCAUSE:   mcause_q   <= wb_i.data;
        // Unknown CSR, write dropped
        default: ;
      endcase
    end
  end

endmodule

//--- rf.sv
`timescale 1ns/1ps

module rf (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic [4:0]                 rs1_adr_i,
  output logic [riscv_pkg::XLEN-1:0] rs1_data_o,
  input  logic [4:0]                 rs2_adr_i,
  output logic [riscv_pkg::XLEN-1:0] rs2_data_o,
  input  riscv_pkg::wb_t             wb_i,
  output riscv_pkg::wb_t             rf_wb_o
);
  import riscv_pkg::*;

  logic [XLEN-1:0] regs [1:31];

  // Write stage, also the forward source for dec
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rf_wb_o <= '0;
    end else begin
      rf_wb_o <= wb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rf_wb_o.v && rf_wb_o.adr != 5'd0) begin
      regs[rf_wb_o.adr] <= rf_wb_o.data;
    end
  end

  // x0 is hardwired
  assign rs1_data_o = (rs1_adr_i == 5'd0) ? '0 : regs[rs1_adr_i];
  assign rs2_data_o = (rs2_adr_i == 5'd0) ? '0 : regs[rs2_adr_i];

endmodule

//--- dec.sv
`timescale 1ns/1ps

module dec (
  input  logic                       clk,
  input  logic                       reset_n,
  input  riscv_pkg::fetch_t          fetch_i,
  output logic [4:0]                 rs1_adr_o,
  input  logic [riscv_pkg::XLEN-1:0] rs1_data_i,
  output logic [4:0]                 rs2_adr_o,
  input  logic [riscv_pkg::XLEN-1:0] rs2_data_i,
  output logic [11:0]                csr_adr_o,
  input  logic [riscv_pkg::XLEN-1:0] csr_data_i,
  input  riscv_pkg::wb_t             exe_wb_i,
  input  riscv_pkg::csr_wb_t         exe_csr_i,
  input  riscv_pkg::wb_t             rf_wb_i,
  output riscv_pkg::dec_exe_t        dec_o
);
  import riscv_pkg::*;

  logic            rd_v, rs1_v, rs2_v;
  logic [4:0]      rd_adr;
  logic            csr_read_v, csr_wbk, csr_clear;
  logic [11:0]     csr_adr;
  logic            auipc, rs1_is_imm, rs2_is_imm, rs2_is_csr;
  logic [XLEN-1:0] imm;
  logic            unsign_ext, rs2_neg;
  unit_e           unit;
  alu_op_e         operation;
  csr_op_e         csr_op;

  logic [XLEN-1:0] ex_data;
  logic            ex_csr_hit;
  logic            exe_csr_hit;
  logic [XLEN-1:0] rs1_fwd, rs2_fwd, csr_val;
  logic [XLEN-1:0] op1, op2;
  logic [XLEN:0]   op1_ext, op2_ext;
  dec_exe_t        dec_nxt;

  decoder decoder_inst (
    .instr_i      (fetch_i.instr),
    .rd_v_o       (rd_v),
    .rd_adr_o     (rd_adr),
    .rs1_v_o      (rs1_v),
    .rs1_adr_o    (rs1_adr_o),
    .rs2_v_o      (rs2_v),
    .rs2_adr_o    (rs2_adr_o),
    .csr_read_v_o (csr_read_v),
    .csr_wbk_o    (csr_wbk),
    .csr_clear_o  (csr_clear),
    .csr_adr_o    (csr_adr),
    .auipc_o      (auipc),
    .rs1_is_imm_o (rs1_is_imm),
    .rs2_is_imm_o (rs2_is_imm),
    .rs2_is_csr_o (rs2_is_csr),
    .imm_o        (imm),
    .unsign_ext_o (unsign_ext),
    .rs2_neg_o    (rs2_neg),
    .unit_o       (unit),
    .operation_o  (operation),
    .csr_op_o     (csr_op)
  );

  // ------------------------------------------------------------------
  // Forwarding, youngest producer wins
  // ------------------------------------------------------------------
  // Instruction now in exe, its result is not registered yet
  assign ex_data = exe_result(dec_o);

  function automatic logic [XLEN-1:0] fwd_gpr(logic [4:0] adr, logic [XLEN-1:0] arr_data);
    logic [XLEN-1:0] data;
    data = arr_data;
    if (rf_wb_i.v && rf_wb_i.adr == adr) data = rf_wb_i.data;
    if (exe_wb_i.v && exe_wb_i.adr == adr) data = exe_wb_i.data;
    if (dec_o.rd_v && dec_o.rd_adr == adr) data = ex_data;
    return data;
  endfunction

  always_comb begin
    rs1_fwd = fwd_gpr(rs1_adr_o, rs1_data_i);
    rs2_fwd = fwd_gpr(rs2_adr_o, rs2_data_i);
  end

  assign ex_csr_hit  = csr_read_v && dec_o.csr_wbk && csr_known(dec_o.csr_adr)
                       && dec_o.csr_adr == csr_adr;
  assign exe_csr_hit = csr_read_v && exe_csr_i.v && exe_csr_i.adr == csr_adr;
  assign csr_val     = ex_csr_hit  ? csr_next(dec_o) :
                       exe_csr_hit ? exe_csr_i.data  : csr_data_i;
  assign csr_adr_o   = csr_adr;

  // ------------------------------------------------------------------
  // Operand qualification
  // ------------------------------------------------------------------
  assign op1 = rs1_v      ? rs1_fwd :
               rs1_is_imm ? imm     :
               auipc      ? fetch_i.pc : '0;
  assign op2 = rs2_v      ? rs2_fwd :
               rs2_is_imm ? imm     :
               rs2_is_csr ? csr_val : '0;

  assign op1_ext = {~unsign_ext & op1[XLEN-1], csr_clear ? ~op1 : op1};
  assign op2_ext = {~unsign_ext & op2[XLEN-1], op2};

  always_comb begin
    dec_nxt.rd_v      = rd_v;
    dec_nxt.rd_adr    = rd_adr;
    dec_nxt.csr_wbk   = csr_wbk;
    dec_nxt.csr_adr   = csr_adr;
    dec_nxt.rs1_qual  = op1_ext;
    dec_nxt.rs2_qual  = rs2_neg ? ~op2_ext + (XLEN+1)'(1) : op2_ext;
    dec_nxt.unit      = unit;
    dec_nxt.operation = operation;
    dec_nxt.csr_op    = csr_op;
    dec_nxt.pc        = fetch_i.pc;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dec_o <= '0;
    end else begin
      dec_o <= dec_nxt;
    end
  end

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
  input  logic [31:0]                instr_i,
  output logic                       rd_v_o,
  output logic [4:0]                 rd_adr_o,
  output logic                       rs1_v_o,
  output logic [4:0]                 rs1_adr_o,
  output logic                       rs2_v_o,
  output logic [4:0]                 rs2_adr_o,
  output logic                       csr_read_v_o,
  output logic                       csr_wbk_o,
  output logic                       csr_clear_o,
  output logic [11:0]                csr_adr_o,
  output logic                       auipc_o,
  output logic                       rs1_is_imm_o,
  output logic                       rs2_is_imm_o,
  output logic                       rs2_is_csr_o,
  output logic [riscv_pkg::XLEN-1:0] imm_o,
  output logic                       unsign_ext_o,
  output logic                       rs2_neg_o,
  output riscv_pkg::unit_e           unit_o,
  output riscv_pkg::alu_op_e         operation_o,
  output riscv_pkg::csr_op_e         csr_op_o
);
  import riscv_pkg::*;

  logic [2:0]      funct3;
  logic            funct7_alt;
  logic            rd_nz;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  alu_op_e         alu_op;

  assign funct3     = instr_i[14:12];
  assign funct7_alt = instr_i[30];
  assign rd_nz      = |instr_i[11:7];
  assign imm_i      = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u      = {instr_i[31:12], 12'b0};

  assign rd_adr_o  = instr_i[11:7];
  assign rs1_adr_o = instr_i[19:15];
  assign rs2_adr_o = instr_i[24:20];
  assign csr_adr_o = instr_i[31:20];

  // SUB shares ALU_ADD, operand 2 gets negated in dec
  always_comb begin
    case (funct3)
      3'b000:  alu_op = ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = funct7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    rd_v_o       = 1'b0;
    rs1_v_o      = 1'b0;
    rs2_v_o      = 1'b0;
    csr_read_v_o = 1'b0;
    csr_wbk_o    = 1'b0;
    csr_clear_o  = 1'b0;
    auipc_o      = 1'b0;
    rs1_is_imm_o = 1'b0;
    rs2_is_imm_o = 1'b0;
    rs2_is_csr_o = 1'b0;
    imm_o        = imm_i;
    unsign_ext_o = 1'b0;
    rs2_neg_o    = 1'b0;
    unit_o       = UNIT_ALU;
    operation_o  = ALU_ADD;
    csr_op_o     = CSR_WRITE;
    case (opcode_e'(instr_i[6:0]))
      OPC_OP_IMM: begin
        rd_v_o       = rd_nz;
        rs1_v_o      = 1'b1;
        rs2_is_imm_o = 1'b1;
        operation_o  = alu_op;
        rs2_neg_o    = (funct3[2:1] == 2'b01);
        unsign_ext_o = (funct3 == 3'b011);
      end
      OPC_OP: begin
        rd_v_o       = rd_nz;
        rs1_v_o      = 1'b1;
        rs2_v_o      = 1'b1;
        operation_o  = alu_op;
        rs2_neg_o    = (funct3 == 3'b000 && funct7_alt) || (funct3[2:1] == 2'b01);
        unsign_ext_o = (funct3 == 3'b011);
      end
      OPC_LUI: begin
        rd_v_o       = rd_nz;
        rs1_is_imm_o = 1'b1;
        imm_o        = imm_u;
        operation_o  = ALU_PASS;
      end
      OPC_AUIPC: begin
        rd_v_o       = rd_nz;
        auipc_o      = 1'b1;
        rs2_is_imm_o = 1'b1;
        imm_o        = imm_u;
      end
      OPC_SYSTEM: begin
        // Register forms only: CSRRW, CSRRS, CSRRC
        if (!funct3[2] && funct3[1:0] != 2'b00) begin
          rd_v_o       = rd_nz;
          rs1_v_o      = 1'b1;
          rs2_is_csr_o = 1'b1;
          csr_read_v_o = 1'b1;
          csr_wbk_o    = (funct3[1:0] == 2'b01) || (|instr_i[19:15]);
          csr_clear_o  = (funct3[1:0] == 2'b11);
          unsign_ext_o = 1'b1;
          unit_o       = UNIT_CSR;
          operation_o  = ALU_PASS;
          csr_op_o     = csr_op_e'(funct3[1:0] - 2'b01);
        end
      end
      default: ;
    endcase
  end

endmodule

//--- if_stage.sv
`timescale 1ns/1ps

module if_stage #(
  parameter logic [riscv_pkg::XLEN-1:0] BOOT_ADDR = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  riscv_pkg::instr_in_t instr_i,
  output riscv_pkg::fetch_t    fetch_o
);
  import riscv_pkg::*;

  logic [XLEN-1:0] pc_q;

  // PC only moves on valid instructions, empty cycles become bubbles
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc_q          <= BOOT_ADDR;
      fetch_o.instr <= NOP_INSTR;
      fetch_o.pc    <= BOOT_ADDR;
    end else if (instr_i.valid) begin
      fetch_o.instr <= instr_i.instr;
      fetch_o.pc    <= pc_q;
      pc_q          <= pc_q + 32'd4;
    end else begin
      fetch_o.instr <= NOP_INSTR;
    end
  end

endmodule

//--- riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN = 32;

  // ADDI x0,x0,0 fills empty fetch slots
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  // Machine CSR addresses
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;

  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic {UNIT_ALU, UNIT_CSR} unit_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS
  } alu_op_e;

  typedef enum logic [1:0] {CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] instr;
  } instr_in_t;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } fetch_t;

  typedef struct packed {
    logic            rd_v;
    logic [4:0]      rd_adr;
    logic            csr_wbk;
    logic [11:0]     csr_adr;
    logic [XLEN:0]   rs1_qual;
    logic [XLEN:0]   rs2_qual;
    unit_e           unit;
    alu_op_e         operation;
    csr_op_e         csr_op;
    logic [XLEN-1:0] pc;
  } dec_exe_t;

  typedef struct packed {
    logic            v;
    logic [4:0]      adr;
    logic [XLEN-1:0] data;
  } wb_t;

  typedef struct packed {
    logic            v;
    logic [11:0]     adr;
    logic [XLEN-1:0] data;
  } csr_wb_t;

  function automatic logic csr_known(logic [11:0] adr);
    return adr inside {CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE};
  endfunction

  // Value written to rd by an instruction in the execute stage
  function automatic logic [XLEN-1:0] exe_result(dec_exe_t d);
    logic [XLEN:0]   sum;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    sum = d.rs1_qual + d.rs2_qual;
    a   = d.rs1_qual[XLEN-1:0];
    b   = d.rs2_qual[XLEN-1:0];
    case (d.operation)
      ALU_ADD:           res = sum[XLEN-1:0];
      ALU_SLL:           res = a << b[4:0];
      ALU_SLT, ALU_SLTU: res = {{(XLEN-1){1'b0}}, sum[XLEN]};
      ALU_XOR:           res = a ^ b;
      ALU_SRL:           res = a >> b[4:0];
      ALU_SRA:           res = $unsigned($signed(a) >>> b[4:0]);
      ALU_OR:            res = a | b;
      ALU_AND:           res = a & b;
      default:           res = a;
    endcase
    // CSR instructions return the old CSR value held in operand 2
    if (d.unit == UNIT_CSR) begin
      res = b;
    end
    return res;
  endfunction

  // New CSR value, operand 1 is already inverted for CSRRC
  function automatic logic [XLEN-1:0] csr_next(dec_exe_t d);
    logic [XLEN-1:0] res;
    case (d.csr_op)
      CSR_SET:   res = d.rs2_qual[XLEN-1:0] | d.rs1_qual[XLEN-1:0];
      CSR_CLEAR: res = d.rs2_qual[XLEN-1:0] & d.rs1_qual[XLEN-1:0];
      default:   res = d.rs1_qual[XLEN-1:0];
    endcase
    return res;
  endfunction

endpackage
